// File: hw/clr_prng_pkg.sv
// Register-clearing PRNG package holding widths, LFSR constants, permutations and shared types.
package clr_prng_pkg;

  // The PRNG state and every key word share this width.
  localparam int PrngWidth = 64;

  // Galois feedback mask for x^64 + x^63 + x^61 + x^60 + 1 with a right-shifting register.
  localparam logic [PrngWidth-1:0] LfsrTaps = 64'hd800_0000_0000_0000;

  // State loaded on reset. It must never be zero or the LFSR locks up.
  localparam logic [PrngWidth-1:0] LfsrDefaultSeed = 64'h8b1e_5c3d_47a9_f206;

  // Output bit i of the first stage takes state bit LfsrPerm[i].
  localparam logic [5:0] LfsrPerm [PrngWidth] = '{
    6'd5,  6'd18, 6'd31, 6'd44, 6'd57, 6'd6,  6'd19, 6'd32,
    6'd45, 6'd58, 6'd7,  6'd20, 6'd33, 6'd46, 6'd59, 6'd8,
    6'd21, 6'd34, 6'd47, 6'd60, 6'd9,  6'd22, 6'd35, 6'd48,
    6'd61, 6'd10, 6'd23, 6'd36, 6'd49, 6'd62, 6'd11, 6'd24,
    6'd37, 6'd50, 6'd63, 6'd12, 6'd25, 6'd38, 6'd51, 6'd0,
    6'd13, 6'd26, 6'd39, 6'd52, 6'd1,  6'd14, 6'd27, 6'd40,
    6'd53, 6'd2,  6'd15, 6'd28, 6'd41, 6'd54, 6'd3,  6'd16,
    6'd29, 6'd42, 6'd55, 6'd4,  6'd17, 6'd30, 6'd43, 6'd56
  };

  // Share 1 bit i takes share 0 bit SharePerm[i].
  localparam logic [5:0] SharePerm [PrngWidth] = '{
    6'd11, 6'd48, 6'd21, 6'd58, 6'd31, 6'd4,  6'd41, 6'd14,
    6'd51, 6'd24, 6'd61, 6'd34, 6'd7,  6'd44, 6'd17, 6'd54,
    6'd27, 6'd0,  6'd37, 6'd10, 6'd47, 6'd20, 6'd57, 6'd30,
    6'd3,  6'd40, 6'd13, 6'd50, 6'd23, 6'd60, 6'd33, 6'd6,
    6'd43, 6'd16, 6'd53, 6'd26, 6'd63, 6'd36, 6'd9,  6'd46,
    6'd19, 6'd56, 6'd29, 6'd2,  6'd39, 6'd12, 6'd49, 6'd22,
    6'd59, 6'd32, 6'd5,  6'd42, 6'd15, 6'd52, 6'd25, 6'd62,
    6'd35, 6'd8,  6'd45, 6'd18, 6'd55, 6'd28, 6'd1,  6'd38
  };

  // The PRINCE S-box, indexed by the input nibble.
  localparam logic [3:0] PrinceSbox [16] = '{
    4'hb, 4'hf, 4'h3, 4'h2, 4'ha, 4'hc, 4'h9, 4'h1,
    4'h6, 4'h7, 4'h8, 4'h0, 4'he, 4'h5, 4'hd, 4'h4
  };

  // Both shares of one key word. Share 0 sits in the lower half.
  typedef struct packed {
    logic [PrngWidth-1:0] share1;
    logic [PrngWidth-1:0] share0;
  } clr_shares_t;

  // Wipe sequencer states.
  typedef enum logic [1:0] {
    WipeIdle,
    WipeReseed,
    WipeRun
  } wipe_state_e;

endpackage

// File: hw/entropy_packer.sv
// Entropy packer that assembles EntropyWidth-bit chunks into one full-width PRNG seed.
`timescale 1ns/1ps

module entropy_packer #(
  parameter int EntropyWidth = 32
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               chunk_valid_i,
  input  logic [EntropyWidth-1:0]            chunk_i,
  output logic [clr_prng_pkg::PrngWidth-1:0] seed_o,
  output logic                               seed_valid_o
);

  // Number of chunks that make up one seed.
  localparam int NumChunks = clr_prng_pkg::PrngWidth / EntropyWidth;

  if (NumChunks == 1) begin : gen_pass
    // A single chunk already covers the whole seed, so it goes straight through.
    assign seed_o       = chunk_i;
    assign seed_valid_o = chunk_valid_i;
  end else begin : gen_pack
    localparam int CntW  = $clog2(NumChunks);
    localparam int PartW = clr_prng_pkg::PrngWidth - EntropyWidth;
    localparam logic [CntW-1:0] LastCnt = CntW'(NumChunks - 1);

    logic [CntW-1:0]  cnt_q;
    logic [CntW-1:0]  cnt_d;
    logic             last_chunk;
    logic [PartW-1:0] part_q;

    // The final chunk is the one that arrives while the counter sits at its top value.
    assign last_chunk = (cnt_q == LastCnt);

    // Count accepted chunks and wrap to zero once a seed has been emitted.
    always_comb begin
      cnt_d = cnt_q;
      if (chunk_valid_i) begin
        if (last_chunk) begin
          cnt_d = '0;
        end else begin
          cnt_d = cnt_q + 1'b1;
        end
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : reg_cnt
      if (!rst_ni) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_d;
      end
    end

    // Earlier chunks shift up one slot as each new chunk enters at the bottom.
    // After all but the last chunk the first one therefore sits at the top.
    always_ff @(posedge clk_i) begin : reg_part
      if (chunk_valid_i && !last_chunk) begin
        part_q <= PartW'({part_q, chunk_i});
      end
    end

    // The last chunk completes the seed combinationally in its own cycle.
    assign seed_o       = {part_q, chunk_i};
    assign seed_valid_o = chunk_valid_i & last_chunk;
  end

  // The chunk width has to divide the seed width evenly.
  initial begin : width_check
    assert (clr_prng_pkg::PrngWidth % EntropyWidth == 0)
      else $error("EntropyWidth %0d does not divide the seed width", EntropyWidth);
  end

endmodule

// File: hw/clearing_lfsr.sv
// Galois LFSR with seed loading and a permuted, S-box substituted non-linear output.
`timescale 1ns/1ps

module clearing_lfsr (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               seed_en_i,
  input  logic [clr_prng_pkg::PrngWidth-1:0] seed_i,
  input  logic                               lfsr_en_i,
  output logic [clr_prng_pkg::PrngWidth-1:0] state_o
);

  localparam int W = clr_prng_pkg::PrngWidth;

  // Number of nibbles passed through the S-box layer.
  localparam int NumNibbles = W / 4;

  logic [W-1:0] state_q;
  logic [W-1:0] state_d;
  logic [W-1:0] step;
  logic [W-1:0] perm_state;

  // One Galois step shifts right and folds the taps in when a one drops out of bit 0.
  assign step = {1'b0, state_q[W-1:1]} ^ (state_q[0] ? clr_prng_pkg::LfsrTaps : '0);

  // A seed load wins over a step that happens in the same cycle.
  always_comb begin
    state_d = state_q;
    if (seed_en_i) begin
      state_d = seed_i;
    end else if (lfsr_en_i) begin
      state_d = step;
    end
  end

  // The state comes out of reset at the default seed so it is never all zeros.
  always_ff @(posedge clk_i or negedge rst_ni) begin : reg_state
    if (!rst_ni) begin
      state_q <= clr_prng_pkg::LfsrDefaultSeed;
    end else begin
      state_q <= state_d;
    end
  end

  // First output stage.
  // The state bits are scattered so that neighbouring state bits end up in different
  // nibbles of the S-box layer.
  always_comb begin
    for (int i = 0; i < W; i++) begin
      perm_state[i] = state_q[clr_prng_pkg::LfsrPerm[i]];
    end
  end

  // Second output stage.
  // Every nibble of the permuted state goes through the PRINCE S-box, which hides the
  // linear structure of the LFSR from whoever sees the output.
  always_comb begin
    for (int j = 0; j < NumNibbles; j++) begin
      state_o[4*j +: 4] = clr_prng_pkg::PrinceSbox[perm_state[4*j +: 4]];
    end
  end

  // The all-zero state is a fixed point of the LFSR and must never be reached.
  state_nonzero_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    state_q != '0
  ) else $error("LFSR state became zero");

  // The entropy source and packer must never hand over an all-zero seed.
  seed_nonzero_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    seed_en_i |-> seed_i != '0
  ) else $error("LFSR seeded with zero");

endmodule

// File: hw/clr_prng.sv
// Clearing PRNG that arbitrates data against reseed requests and builds both wipe shares.
`timescale 1ns/1ps

module clr_prng #(
  parameter int EntropyWidth = 32
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  // Consumer side.
  input  logic                      data_req_i,
  output logic                      data_ack_o,
  output clr_prng_pkg::clr_shares_t data_o,
  input  logic                      reseed_req_i,
  output logic                      reseed_ack_o,

  // Entropy source side.
  output logic                      entropy_req_o,
  input  logic                      entropy_ack_i,
  input  logic [EntropyWidth-1:0]   entropy_i
);

  localparam int W = clr_prng_pkg::PrngWidth;

  logic         chunk_valid;
  logic         seed_valid;
  logic [W-1:0] seed;
  logic         lfsr_en;
  logic [W-1:0] lfsr_state;

  // A pending reseed blocks data so that no word is taken from a stale state.
  assign data_ack_o = reseed_req_i ? 1'b0 : data_req_i;

  // Every acknowledged data word is consumed, so the LFSR moves on at that edge.
  assign lfsr_en = data_req_i & data_ack_o;

  // Entropy is requested for as long as the consumer holds its reseed request.
  // The consumer drops that request right after the acknowledge edge.
  assign entropy_req_o = reseed_req_i;
  assign chunk_valid   = entropy_req_o & entropy_ack_i;

  // The reseed completes in the cycle that delivers the last chunk.
  assign reseed_ack_o = seed_valid;

  entropy_packer #(
    .EntropyWidth ( EntropyWidth )
  ) u_packer (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .chunk_valid_i ( chunk_valid ),
    .chunk_i       ( entropy_i   ),
    .seed_o        ( seed        ),
    .seed_valid_o  ( seed_valid  )
  );

  clearing_lfsr u_lfsr (
    .clk_i     ( clk_i      ),
    .rst_ni    ( rst_ni     ),
    .seed_en_i ( seed_valid ),
    .seed_i    ( seed       ),
    .lfsr_en_i ( lfsr_en    ),
    .state_o   ( lfsr_state )
  );

  // Share 0 is the LFSR output itself.
  // Share 1 is a second fixed scramble of the same bits.
  always_comb begin
    data_o.share0 = lfsr_state;
    for (int i = 0; i < W; i++) begin
      data_o.share1[i] = lfsr_state[clr_prng_pkg::SharePerm[i]];
    end
  end

  // No data word may leave while the consumer is waiting for fresh entropy.
  no_data_during_reseed_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(data_ack_o && reseed_req_i)
  ) else $error("Data acknowledged during a reseed");

  // The consumer holds its reseed request until the acknowledge has arrived.
  reseed_req_held_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $fell(reseed_req_i) |-> $past(reseed_ack_o)
  ) else $error("Reseed request dropped before the acknowledge");

  // Each share 0 bit must appear exactly once in share 1.
  initial begin : share_perm_check
    logic [W-1:0] hit;
    hit = '0;
    for (int k = 0; k < W; k++) begin
      hit[clr_prng_pkg::SharePerm[k]] = 1'b1;
    end
    assert (&hit) else $error("SharePerm is not a permutation");
  end

endmodule

// File: hw/key_wipe_ctrl.sv
// Two-share key register file with load and read ports and a PRNG driven wipe sequencer.
`timescale 1ns/1ps

module key_wipe_ctrl #(
  parameter  int NumWords = 4,
  localparam int IdxW     = $clog2(NumWords)
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  // Key load and read ports.
  input  logic                      load_i,
  input  logic [IdxW-1:0]           load_idx_i,
  input  clr_prng_pkg::clr_shares_t load_data_i,
  input  logic [IdxW-1:0]           rd_idx_i,
  output clr_prng_pkg::clr_shares_t rd_data_o,

  // Wipe control.
  input  logic                      wipe_i,
  input  logic                      reseed_i,
  output logic                      busy_o,
  output logic                      done_o,

  // PRNG side.
  output logic                      data_req_o,
  input  logic                      data_ack_i,
  input  clr_prng_pkg::clr_shares_t data_i,
  output logic                      reseed_req_o,
  input  logic                      reseed_ack_i
);

  localparam logic [IdxW-1:0] LastIdx = IdxW'(NumWords - 1);

  clr_prng_pkg::wipe_state_e state_q;
  clr_prng_pkg::wipe_state_e state_d;
  logic [IdxW-1:0]           cnt_q;
  logic [IdxW-1:0]           cnt_d;
  logic                      done_q;
  logic                      done_d;
  logic                      last_word;
  logic                      wr_en;
  logic [IdxW-1:0]           wr_idx;
  clr_prng_pkg::clr_shares_t wr_data;
  clr_prng_pkg::clr_shares_t regs_q [NumWords];

  // Requests and status come straight from the state.
  assign data_req_o   = (state_q == clr_prng_pkg::WipeRun);
  assign reseed_req_o = (state_q == clr_prng_pkg::WipeReseed);
  assign busy_o       = (state_q != clr_prng_pkg::WipeIdle);
  assign done_o       = done_q;
  assign last_word    = (cnt_q == LastIdx);

  // Wipe sequencer.
  // Requests are only taken in idle, and an optional reseed runs before the word loop.
  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    done_d  = 1'b0;
    unique case (state_q)
      clr_prng_pkg::WipeIdle: begin
        cnt_d = '0;
        if (wipe_i && reseed_i) begin
          state_d = clr_prng_pkg::WipeReseed;
        end else if (wipe_i) begin
          state_d = clr_prng_pkg::WipeRun;
        end
      end
      clr_prng_pkg::WipeReseed: begin
        if (reseed_ack_i) begin
          state_d = clr_prng_pkg::WipeRun;
        end
      end
      clr_prng_pkg::WipeRun: begin
        // One word is written per acknowledged request, lowest index first.
        if (data_ack_i && last_word) begin
          state_d = clr_prng_pkg::WipeIdle;
          cnt_d   = '0;
          done_d  = 1'b1;
        end else if (data_ack_i) begin
          cnt_d = cnt_q + 1'b1;
        end
      end
      default: state_d = clr_prng_pkg::WipeIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : reg_ctrl
    if (!rst_ni) begin
      state_q <= clr_prng_pkg::WipeIdle;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      done_q  <= done_d;
    end
  end

  // The wipe owns the write port while it runs.
  // Loads go through only in idle and only to a word that exists.
  always_comb begin
    if (state_q == clr_prng_pkg::WipeRun) begin
      wr_en   = data_req_o & data_ack_i;
      wr_idx  = cnt_q;
      wr_data = data_i;
    end else begin
      wr_en   = load_i && (state_q == clr_prng_pkg::WipeIdle) && (load_idx_i <= LastIdx);
      wr_idx  = load_idx_i;
      wr_data = load_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : reg_file
    if (!rst_ni) begin
      for (int w = 0; w < NumWords; w++) begin
        regs_q[w] <= '0;
      end
    end else if (wr_en) begin
      regs_q[wr_idx] <= wr_data;
    end
  end

  // Reads are combinational, and an index past the last word reads as zero.
  assign rd_data_o = (rd_idx_i <= LastIdx) ? regs_q[rd_idx_i] : '0;

  // Data is only ever requested from inside a wipe.
  no_req_in_idle_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    data_req_o |-> state_q != clr_prng_pkg::WipeIdle
  ) else $error("Data requested while idle");

  // The word counter stays within the register file.
  cnt_in_range_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= LastIdx
  ) else $error("Wipe word counter out of range");

endmodule

// File: hw/clr_prng_top.sv
// Top level joining the key wipe controller to the clearing PRNG and the entropy port.
`timescale 1ns/1ps

module clr_prng_top #(
  parameter  int EntropyWidth = 32,
  parameter  int NumWords     = 4,
  localparam int IdxW         = $clog2(NumWords)
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      load_i,
  input  logic [IdxW-1:0]           load_idx_i,
  input  clr_prng_pkg::clr_shares_t load_data_i,
  input  logic [IdxW-1:0]           rd_idx_i,
  output clr_prng_pkg::clr_shares_t rd_data_o,
  input  logic                      wipe_i,
  input  logic                      reseed_i,
  output logic                      busy_o,
  output logic                      done_o,
  output logic                      entropy_req_o,
  input  logic                      entropy_ack_i,
  input  logic [EntropyWidth-1:0]   entropy_i
);

  // Handshakes between the wipe controller and the PRNG.
  logic                      data_req;
  logic                      data_ack;
  clr_prng_pkg::clr_shares_t data;
  logic                      reseed_req;
  logic                      reseed_ack;

  key_wipe_ctrl #(
    .NumWords ( NumWords )
  ) u_wipe_ctrl (
    .clk_i        ( clk_i       ),
    .rst_ni       ( rst_ni      ),
    .load_i       ( load_i      ),
    .load_idx_i   ( load_idx_i  ),
    .load_data_i  ( load_data_i ),
    .rd_idx_i     ( rd_idx_i    ),
    .rd_data_o    ( rd_data_o   ),
    .wipe_i       ( wipe_i      ),
    .reseed_i     ( reseed_i    ),
    .busy_o       ( busy_o      ),
    .done_o       ( done_o      ),
    .data_req_o   ( data_req    ),
    .data_ack_i   ( data_ack    ),
    .data_i       ( data        ),
    .reseed_req_o ( reseed_req  ),
    .reseed_ack_i ( reseed_ack  )
  );

  clr_prng #(
    .EntropyWidth ( EntropyWidth )
  ) u_prng (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .data_req_i    ( data_req      ),
    .data_ack_o    ( data_ack      ),
    .data_o        ( data          ),
    .reseed_req_i  ( reseed_req    ),
    .reseed_ack_o  ( reseed_ack    ),
    .entropy_req_o ( entropy_req_o ),
    .entropy_ack_i ( entropy_ack_i ),
    .entropy_i     ( entropy_i     )
  );

endmodule

// File: verification/clr_prng_model.svh
// Reference model of the clearing PRNG for the testbench, with LFSR, output, share and LCG functions.
`ifndef CLR_PRNG_MODEL_SVH
`define CLR_PRNG_MODEL_SVH

  // One Galois step shifts right and folds in the tap mask when a one drops out of bit 0.
  function automatic logic [63:0] model_lfsr_step(input logic [63:0] s);
    logic [63:0] taps;
    taps = s[0] ? clr_prng_pkg::LfsrTaps : 64'h0;
    return {1'b0, s[63:1]} ^ taps;
  endfunction

  // The output scatters the state bits first, then substitutes every nibble.
  function automatic logic [63:0] model_output(input logic [63:0] s);
    logic [63:0] p;
    logic [63:0] o;
    for (int i = 0; i < 64; i++) begin
      p[i] = s[clr_prng_pkg::LfsrPerm[i]];
    end
    for (int j = 0; j < 16; j++) begin
      o[4*j +: 4] = clr_prng_pkg::PrinceSbox[p[4*j +: 4]];
    end
    return o;
  endfunction

  // Share 1 bit i is share 0 bit SharePerm[i].
  function automatic logic [63:0] model_share1(input logic [63:0] share0);
    logic [63:0] s1;
    for (int i = 0; i < 64; i++) begin
      s1[i] = share0[clr_prng_pkg::SharePerm[i]];
    end
    return s1;
  endfunction

  // Both shares of the word that the PRNG shows for state s.
  function automatic clr_prng_pkg::clr_shares_t model_shares(input logic [63:0] s);
    clr_prng_pkg::clr_shares_t w;
    w.share0 = model_output(s);
    w.share1 = model_share1(w.share0);
    return w;
  endfunction

  // Linear congruential generator for the entropy data and the acknowledge gaps.
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

`endif

// File: verification/clr_prng_tb.sv
// Testbench for the clearing PRNG top level, driving a table of loads, wipes and reads.
`timescale 1ns/1ps

module clr_prng_tb;

  localparam int EntropyWidth = 32;
  localparam int NumWords     = 4;
  localparam int IdxW         = 2;
  localparam int Timeout      = 100;
  localparam int NumRows      = 17;

  localparam logic [1:0] OpLoad       = 2'd0;
  localparam logic [1:0] OpWipe       = 2'd1;
  localparam logic [1:0] OpWipeReseed = 2'd2;
  localparam logic [1:0] OpRead       = 2'd3;

  // One row of the operation table.
  // For a wipe the data is the load that is tried while busy_o is high.
  typedef struct packed {
    logic [1:0]                op;
    logic [IdxW-1:0]           idx;
    clr_prng_pkg::clr_shares_t data;
  } row_t;

  localparam row_t OpTable [NumRows] = '{
    {OpLoad,       2'd1, 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210},
    {OpRead,       2'd1, 128'h0},
    {OpLoad,       2'd3, 128'hdead_beef_0bad_f00d_1357_9bdf_2468_ace0},
    {OpRead,       2'd3, 128'h0},
    {OpRead,       2'd0, 128'h0},
    {OpWipe,       2'd2, 128'hffff_0000_ffff_0000_a5a5_a5a5_5a5a_5a5a},
    {OpRead,       2'd0, 128'h0},
    {OpRead,       2'd1, 128'h0},
    {OpRead,       2'd2, 128'h0},
    {OpRead,       2'd3, 128'h0},
    {OpLoad,       2'd2, 128'h5a5a_1111_2222_3333_4444_5555_6666_7777},
    {OpRead,       2'd2, 128'h0},
    {OpWipeReseed, 2'd0, 128'hcafe_babe_cafe_babe_0000_1111_2222_3333},
    {OpRead,       2'd0, 128'h0},
    {OpRead,       2'd3, 128'h0},
    {OpWipe,       2'd1, 128'h1234_1234_1234_1234_4321_4321_4321_4321},
    {OpRead,       2'd1, 128'h0}
  };

  logic                      clk_i;
  logic                      rst_ni;
  logic                      load_i;
  logic [IdxW-1:0]           load_idx_i;
  clr_prng_pkg::clr_shares_t load_data_i;
  logic [IdxW-1:0]           rd_idx_i;
  clr_prng_pkg::clr_shares_t rd_data_o;
  logic                      wipe_i;
  logic                      reseed_i;
  logic                      busy_o;
  logic                      done_o;
  logic                      entropy_req_o;
  logic                      entropy_ack_i;
  logic [EntropyWidth-1:0]   entropy_i;

  // Model of the LFSR state and of the register file contents.
  logic [63:0]               model_state;
  clr_prng_pkg::clr_shares_t exp_regs [NumWords];
  logic [EntropyWidth-1:0]   chunks [$];

  `include "clr_prng_model.svh"

  clr_prng_top #(
    .EntropyWidth ( EntropyWidth ),
    .NumWords     ( NumWords     )
  ) uut (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .load_i        ( load_i        ),
    .load_idx_i    ( load_idx_i    ),
    .load_data_i   ( load_data_i   ),
    .rd_idx_i      ( rd_idx_i      ),
    .rd_data_o     ( rd_data_o     ),
    .wipe_i        ( wipe_i        ),
    .reseed_i      ( reseed_i      ),
    .busy_o        ( busy_o        ),
    .done_o        ( done_o        ),
    .entropy_req_o ( entropy_req_o ),
    .entropy_ack_i ( entropy_ack_i ),
    .entropy_i     ( entropy_i     )
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Inputs change and outputs are sampled 10 ns after the rising edge.
  task automatic next_cycle();
    @(posedge clk_i);
    #10;
  endtask

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    assert (got === exp) else begin
      $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timed out while waiting for %s", what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // The read port is combinational, so the data is checked shortly after the index moves.
  task automatic read_word(input logic [IdxW-1:0] idx);
    rd_idx_i = idx;
    #1;
    check_value($sformatf("rd_data_o[%0d]", idx), rd_data_o, exp_regs[idx]);
  endtask

  task automatic load_word(input logic [IdxW-1:0] idx, input clr_prng_pkg::clr_shares_t data);
    load_i      = 1'b1;
    load_idx_i  = idx;
    load_data_i = data;
    next_cycle();
    load_i        = 1'b0;
    exp_regs[idx] = data;
  endtask

  task automatic wipe_regs(input logic reseed, input logic [IdxW-1:0] idx,
                           input clr_prng_pkg::clr_shares_t data);
    int n;
    chunks.delete();
    wipe_i   = 1'b1;
    reseed_i = reseed;
    next_cycle();
    wipe_i   = 1'b0;
    reseed_i = 1'b0;
    check_value("busy_o", 128'(busy_o), 128'h1);
    check_value("entropy_req_o", 128'(entropy_req_o), 128'(reseed));
    // This load arrives while busy_o is high and has to be dropped.
    load_i      = 1'b1;
    load_idx_i  = idx;
    load_data_i = data;
    if (reseed) begin
      n = 0;
      while (entropy_req_o) begin
        next_cycle();
        load_i = 1'b0;
        n++;
        if (n == Timeout) stop_on_timeout("entropy_req_o to fall");
      end
      check_value("entropy chunk count", 128'(chunks.size()), 128'd2);
      // The first chunk fills the upper half of the new seed.
      model_state = {chunks[0], chunks[1]};
    end
    // One word is written per cycle, so done_o follows NumWords cycles into the run.
    n = 0;
    while (!done_o) begin
      next_cycle();
      load_i = 1'b0;
      n++;
      if (n == Timeout) stop_on_timeout("done_o");
    end
    check_value("wipe cycles", 128'(n), 128'(NumWords));
    check_value("busy_o", 128'(busy_o), 128'h0);
    for (int k = 0; k < NumWords; k++) begin
      exp_regs[k] = model_shares(model_state);
      model_state = model_lfsr_step(model_state);
    end
    for (int k = 0; k < NumWords; k++) begin
      read_word(IdxW'(k));
      check_value("rd_data_o.share1", 128'(rd_data_o.share1),
                  128'(model_share1(exp_regs[k].share0)));
    end
    next_cycle();
    check_value("done_o", 128'(done_o), 128'h0);
  endtask

  // The entropy source answers each request after a random gap with a random chunk.
  initial begin : entropy_responder
    logic [31:0] lcg;
    logic [1:0]  gap;
    lcg           = 32'h4b3575ac;
    lcg           = lcg_next(lcg);
    gap           = lcg[31:30];
    entropy_ack_i = 1'b0;
    entropy_i     = '0;
    forever begin
      next_cycle();
      entropy_ack_i = 1'b0;
      if (rst_ni && entropy_req_o) begin
        if (gap == 2'd0) begin
          lcg           = lcg_next(lcg);
          entropy_i     = lcg;
          entropy_ack_i = 1'b1;
          chunks.push_back(lcg);
          lcg = lcg_next(lcg);
          gap = lcg[31:30];
        end else begin
          gap = gap - 2'd1;
        end
      end
    end
  end

  initial begin : main_sequence
    row_t row;
    rst_ni      = 1'b0;
    load_i      = 1'b0;
    load_idx_i  = '0;
    load_data_i = '0;
    rd_idx_i    = '0;
    wipe_i      = 1'b0;
    reseed_i    = 1'b0;
    model_state = clr_prng_pkg::LfsrDefaultSeed;
    for (int w = 0; w < NumWords; w++) begin
      exp_regs[w] = '0;
    end
    repeat (10) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;

    // Everything is quiet and cleared out of reset.
    check_value("entropy_req_o", 128'(entropy_req_o), 128'h0);
    check_value("busy_o", 128'(busy_o), 128'h0);
    check_value("done_o", 128'(done_o), 128'h0);
    for (int w = 0; w < NumWords; w++) begin
      read_word(IdxW'(w));
    end

    for (int r = 0; r < NumRows; r++) begin
      row = OpTable[r];
      case (row.op)
        OpLoad:       load_word(row.idx, row.data);
        OpWipe:       wipe_regs(1'b0, row.idx, row.data);
        OpWipeReseed: wipe_regs(1'b1, row.idx, row.data);
        default:      read_word(row.idx);
      endcase
    end

    $display("TEST OK");
    $finish;
  end

endmodule

// File: flist.f
+incdir+verification
hw/clr_prng_pkg.sv
hw/entropy_packer.sv
hw/clearing_lfsr.sv
hw/clr_prng.sv
hw/key_wipe_ctrl.sv
hw/clr_prng_top.sv
verification/clr_prng_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 -f flist.f --top-module clr_prng_tb -o clr_prng_sim

# The simulator exits non-zero on a fatal check, so the log decides the result.
./obj_dir/clr_prng_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q "TEST OK" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
